// ==== src/chi_link_pkg.sv ====
`default_nettype none

package chi_link_pkg;

    // flit widths per channel
    localparam int unsigned REQ_FLIT_W = 32;
    localparam int unsigned RSP_FLIT_W = 24;
    localparam int unsigned DAT_FLIT_W = 48;

    typedef logic [REQ_FLIT_W-1:0] req_flit_t;
    typedef logic [RSP_FLIT_W-1:0] rsp_flit_t;
    typedef logic [DAT_FLIT_W-1:0] dat_flit_t;

    // fields shared by every flit type
    localparam int unsigned OPCODE_LSB = 0;
    localparam int unsigned OPCODE_W   = 4;
    localparam int unsigned SRCID_LSB  = 4;
    localparam int unsigned SRCID_W    = 7;

    // link credit return opcode, same on all channels
    localparam logic [OPCODE_W-1:0] LCRD_RETURN_OP = 4'h0;

    localparam int unsigned LCRD_NUM_DEF = 15;

    // encoded as {linkactivereq, linkactiveack}
    typedef enum logic [1:0] {
        STOP       = 2'b00,
        ACTIVATE   = 2'b10,
        RUN        = 2'b11,
        DEACTIVATE = 2'b01
    } link_state_t;

endpackage

`default_nettype wire

// ==== src/lcrd_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcrd_counter #(
    parameter int unsigned INIT_CNT = 0,
    parameter int unsigned MAX_CNT  = 15
) (
    input  logic clk_i,
    input  logic rst_i,
    input  logic inc_i,
    input  logic dec_i,
    output logic avail_o,
    output logic full_o
);

    localparam int unsigned CNT_W = $clog2(MAX_CNT + 1);

    localparam logic [CNT_W-1:0] INIT_VAL = CNT_W'(INIT_CNT);
    localparam logic [CNT_W-1:0] MAX_VAL  = CNT_W'(MAX_CNT);

    logic [CNT_W-1:0] cnt_q;

    // inc and dec together cancel out
    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            cnt_q <= INIT_VAL;
        end else if (inc_i && !dec_i && !full_o) begin
            cnt_q <= cnt_q + 1'b1;
        end else if (dec_i && !inc_i && avail_o) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    assign avail_o = (cnt_q != '0);
    assign full_o  = (cnt_q == MAX_VAL);

endmodule

`default_nettype wire

// ==== src/link_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module link_fsm (
    input  logic clk_i,
    input  logic rst_i,

    input  logic link_en_i,

    // transmit direction handshake
    input  logic txlinkactiveack_i,
    output logic txlinkactivereq_o,

    // receive direction handshake
    input  logic rxlinkactivereq_i,
    output logic rxlinkactiveack_o,

    // all receive credits back home
    input  logic rsp_crd_full_i,
    input  logic dat_crd_full_i,

    output logic tx_run_o,
    output logic tx_return_o,
    output logic rx_crd_en_o
);

    chi_link_pkg::link_state_t tx_state;
    chi_link_pkg::link_state_t rx_state;

    logic rx_crd_home;

    // ************************************************************************
    // transmit side
    // ************************************************************************

    // request only once the partner has finished the previous deactivation
    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            txlinkactivereq_o <= 1'b0;
        end else if (!link_en_i) begin
            txlinkactivereq_o <= 1'b0;
        end else if (!txlinkactiveack_i) begin
            txlinkactivereq_o <= 1'b1;
        end
    end

    assign tx_state = chi_link_pkg::link_state_t'({txlinkactivereq_o, txlinkactiveack_i});

    assign tx_run_o    = (tx_state == chi_link_pkg::RUN);
    assign tx_return_o = (tx_state == chi_link_pkg::DEACTIVATE);

    // ************************************************************************
    // receive side
    // ************************************************************************

    assign rx_state = chi_link_pkg::link_state_t'({rxlinkactivereq_i, rxlinkactiveack_o});

    assign rx_crd_home = rsp_crd_full_i & dat_crd_full_i;

    // ack drops only after the partner has returned every credit
    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            rxlinkactiveack_o <= 1'b0;
        end else if (rx_state == chi_link_pkg::ACTIVATE) begin
            rxlinkactiveack_o <= 1'b1;
        end else if (rx_state == chi_link_pkg::DEACTIVATE && rx_crd_home) begin
            rxlinkactiveack_o <= 1'b0;
        end
    end

    // credits are handed out only in run
    assign rx_crd_en_o = (rx_state == chi_link_pkg::RUN);

endmodule

`default_nettype wire

// ==== src/rx_chan.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_chan #(
    parameter type         flit_t   = chi_link_pkg::rsp_flit_t,
    parameter int unsigned LCRD_NUM = chi_link_pkg::LCRD_NUM_DEF
) (
    input  logic  clk_i,
    input  logic  rst_i,

    // network side
    input  logic  flitv_i,
    input  flit_t flit_i,
    input  logic  crd_en_i,
    output logic  lcrdv_o,
    output logic  crd_full_o,

    // local side
    output logic  valid_o,
    output flit_t flit_o
);

    logic  flitv_q;
    flit_t flit_q;
    logic  crd_avail;
    logic  crd_grant;

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            flitv_q <= 1'b0;
        end else begin
            flitv_q <= flitv_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (flitv_i) begin
            flit_q <= flit_i;
        end
    end

    // credit returns are consumed here
    assign valid_o = flitv_q &
        (flit_q[chi_link_pkg::OPCODE_LSB +: chi_link_pkg::OPCODE_W] !=
         chi_link_pkg::LCRD_RETURN_OP);
    assign flit_o  = flit_q;

    // one grant per cycle while enabled
    assign crd_grant = crd_avail & crd_en_i;

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            lcrdv_o <= 1'b0;
        end else begin
            lcrdv_o <= crd_grant;
        end
    end

    // every received flit brings its credit back
    lcrd_counter #(
        .INIT_CNT (LCRD_NUM),
        .MAX_CNT  (LCRD_NUM)
    ) lcrd_counter_i (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .inc_i   (flitv_q),
        .dec_i   (crd_grant),
        .avail_o (crd_avail),
        .full_o  (crd_full_o)
    );

endmodule

`default_nettype wire

// ==== src/tx_req_chan.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_req_chan #(
    parameter logic [chi_link_pkg::SRCID_W-1:0] NODE_ID  = '0,
    parameter int unsigned                      LCRD_NUM = chi_link_pkg::LCRD_NUM_DEF
) (
    input  logic                  clk_i,
    input  logic                  rst_i,

    input  logic                  tx_run_i,
    input  logic                  tx_return_i,

    input  logic                  lcrdv_i,

    // read source
    input  logic                  rd_valid_i,
    input  chi_link_pkg::req_flit_t rd_flit_i,
    output logic                  rd_ready_o,

    // write source
    input  logic                  wr_valid_i,
    input  chi_link_pkg::req_flit_t wr_flit_i,
    output logic                  wr_ready_o,

    // network side
    output logic                  flitv_o,
    output chi_link_pkg::req_flit_t flit_o
);

    logic                    crd_avail;
    logic                    send_ok;
    logic                    prio_wr_q;
    logic                    sel_rd;
    logic                    sel_wr;
    logic                    lcrd_ret;
    logic                    sent;
    chi_link_pkg::req_flit_t ret_flit;
    chi_link_pkg::req_flit_t next_flit;
    chi_link_pkg::req_flit_t flit_q;

    // ************************************************************************
    // round robin between read and write
    // ************************************************************************

    assign sel_wr = wr_valid_i & (!rd_valid_i | prio_wr_q);
    assign sel_rd = rd_valid_i & (!wr_valid_i | !prio_wr_q);

    // read goes first out of reset
    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            prio_wr_q <= 1'b0;
        end else if (rd_ready_o) begin
            prio_wr_q <= 1'b1;
        end else if (wr_ready_o) begin
            prio_wr_q <= 1'b0;
        end
    end

    assign send_ok    = tx_run_i & crd_avail;
    assign rd_ready_o = sel_rd & send_ok;
    assign wr_ready_o = sel_wr & send_ok;

    // ************************************************************************
    // credit return and output register
    // ************************************************************************

    always_comb begin
        ret_flit = '0;
        ret_flit[chi_link_pkg::OPCODE_LSB +: chi_link_pkg::OPCODE_W] =
            chi_link_pkg::LCRD_RETURN_OP;
        ret_flit[chi_link_pkg::SRCID_LSB +: chi_link_pkg::SRCID_W] = NODE_ID;
    end

    // drain held credits while deactivating
    assign lcrd_ret = tx_return_i & crd_avail;
    assign sent     = rd_ready_o | wr_ready_o | lcrd_ret;

    assign next_flit = lcrd_ret ? ret_flit :
                       sel_wr   ? wr_flit_i : rd_flit_i;

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            flitv_o <= 1'b0;
        end else begin
            flitv_o <= sent;
        end
    end

    always_ff @(posedge clk_i) begin
        if (sent) begin
            flit_q <= next_flit;
        end
    end

    assign flit_o = flit_q;

    // starts empty, filled by the partner
    lcrd_counter #(
        .INIT_CNT (0),
        .MAX_CNT  (LCRD_NUM)
    ) lcrd_counter_i (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .inc_i   (lcrdv_i),
        .dec_i   (sent),
        .avail_o (crd_avail),
        .full_o  ()
    );

endmodule

`default_nettype wire

// ==== src/chi_link_ctl.sv ====
`timescale 1ns/1ps
`default_nettype none

module chi_link_ctl #(
    parameter logic [chi_link_pkg::SRCID_W-1:0] NODE_ID  = 7'h11,
    parameter int unsigned                      LCRD_NUM = chi_link_pkg::LCRD_NUM_DEF
) (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    link_en_i,

    // link handshake
    output logic                    txlinkactivereq_o,
    input  logic                    txlinkactiveack_i,
    input  logic                    rxlinkactivereq_i,
    output logic                    rxlinkactiveack_o,

    // receive channels
    input  logic                    rxrspflitv_i,
    input  chi_link_pkg::rsp_flit_t rxrspflit_i,
    output logic                    rxrsplcrdv_o,
    input  logic                    rxdatflitv_i,
    input  chi_link_pkg::dat_flit_t rxdatflit_i,
    output logic                    rxdatlcrdv_o,

    // transmit request channel
    output logic                    txreqflitv_o,
    output chi_link_pkg::req_flit_t txreqflit_o,
    input  logic                    txreqlcrdv_i,

    // local request sources
    input  logic                    rd_req_valid_i,
    input  chi_link_pkg::req_flit_t rd_req_flit_i,
    output logic                    rd_req_ready_o,
    input  logic                    wr_req_valid_i,
    input  chi_link_pkg::req_flit_t wr_req_flit_i,
    output logic                    wr_req_ready_o,

    // local receive outputs
    output logic                    rsp_valid_o,
    output chi_link_pkg::rsp_flit_t rsp_flit_o,
    output logic                    dat_valid_o,
    output chi_link_pkg::dat_flit_t dat_flit_o
);

    logic tx_run;
    logic tx_return;
    logic rx_crd_en;
    logic rsp_crd_full;
    logic dat_crd_full;

    link_fsm link_fsm_i (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .link_en_i         (link_en_i),
        .txlinkactiveack_i (txlinkactiveack_i),
        .txlinkactivereq_o (txlinkactivereq_o),
        .rxlinkactivereq_i (rxlinkactivereq_i),
        .rxlinkactiveack_o (rxlinkactiveack_o),
        .rsp_crd_full_i    (rsp_crd_full),
        .dat_crd_full_i    (dat_crd_full),
        .tx_run_o          (tx_run),
        .tx_return_o       (tx_return),
        .rx_crd_en_o       (rx_crd_en)
    );

    rx_chan #(
        .flit_t   (chi_link_pkg::rsp_flit_t),
        .LCRD_NUM (LCRD_NUM)
    ) rx_rsp_i (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .flitv_i    (rxrspflitv_i),
        .flit_i     (rxrspflit_i),
        .crd_en_i   (rx_crd_en),
        .lcrdv_o    (rxrsplcrdv_o),
        .crd_full_o (rsp_crd_full),
        .valid_o    (rsp_valid_o),
        .flit_o     (rsp_flit_o)
    );

    rx_chan #(
        .flit_t   (chi_link_pkg::dat_flit_t),
        .LCRD_NUM (LCRD_NUM)
    ) rx_dat_i (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .flitv_i    (rxdatflitv_i),
        .flit_i     (rxdatflit_i),
        .crd_en_i   (rx_crd_en),
        .lcrdv_o    (rxdatlcrdv_o),
        .crd_full_o (dat_crd_full),
        .valid_o    (dat_valid_o),
        .flit_o     (dat_flit_o)
    );

    tx_req_chan #(
        .NODE_ID  (NODE_ID),
        .LCRD_NUM (LCRD_NUM)
    ) tx_req_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .tx_run_i    (tx_run),
        .tx_return_i (tx_return),
        .lcrdv_i     (txreqlcrdv_i),
        .rd_valid_i  (rd_req_valid_i),
        .rd_flit_i   (rd_req_flit_i),
        .rd_ready_o  (rd_req_ready_o),
        .wr_valid_i  (wr_req_valid_i),
        .wr_flit_i   (wr_req_flit_i),
        .wr_ready_o  (wr_req_ready_o),
        .flitv_o     (txreqflitv_o),
        .flit_o      (txreqflit_o)
    );

endmodule

`default_nettype wire

// ==== dv/chi_link_tests.svh ====
`ifndef CHI_LINK_TESTS_SVH
`define CHI_LINK_TESTS_SVH

// ************************************************************************
// transmit side bring-up
// ************************************************************************

task automatic test_reset_activate();
    int          n;
    logic [63:0] r;
    logic [8:0]  outs;
    begin_test("reset_activate");
    @(negedge clk_i);
    outs = {txlinkactivereq_o, rxlinkactiveack_o, rxrsplcrdv_o, rxdatlcrdv_o,
            txreqflitv_o, rsp_valid_o, dat_valid_o, rd_req_ready_o, wr_req_ready_o};
    if (outs !== 9'h0) report_mismatch(64'h0, 64'(outs));

    @(posedge clk_i);
    link_en_i <= 1'b1;
    n = 0;
    while (txlinkactivereq_o !== 1'b1 && n < 10) begin
        @(negedge clk_i);
        n++;
    end
    if (txlinkactivereq_o !== 1'b1) note_error("txlinkactivereq_o never rose");

    // partner acks, link runs but holds no credits yet
    @(posedge clk_i);
    txlinkactiveack_i <= 1'b1;
    r = rand_bits(32);
    rd_req_valid_i <= 1'b1;
    rd_req_flit_i <= r[31:0];
    r = rand_bits(32);
    wr_req_valid_i <= 1'b1;
    wr_req_flit_i <= r[31:0];
    ready_seen = 1'b0;
    repeat (8) @(negedge clk_i);
    if (ready_seen) note_error("a ready rose without transmit credits");
    @(posedge clk_i);
    rd_req_valid_i <= 1'b0;
    wr_req_valid_i <= 1'b0;
    end_test();
endtask

// ************************************************************************
// receive channels
// ************************************************************************

task automatic test_rx_credit_grant();
    int n;
    int rsp0;
    int dat0;
    begin_test("rx_credit_grant");
    rsp0 = rsp_grants;
    dat0 = dat_grants;
    @(posedge clk_i);
    rxlinkactivereq_i <= 1'b1;
    n = 0;
    while (rxlinkactiveack_o !== 1'b1 && n < 10) begin
        @(negedge clk_i);
        n++;
    end
    if (rxlinkactiveack_o !== 1'b1) note_error("rxlinkactiveack_o never rose");
    repeat (LCRD_NUM + 10) @(negedge clk_i);
    if (rsp_grants - rsp0 != LCRD_NUM) report_mismatch(64'(LCRD_NUM), 64'(rsp_grants - rsp0));
    if (dat_grants - dat0 != LCRD_NUM) report_mismatch(64'(LCRD_NUM), 64'(dat_grants - dat0));
    end_test();
endtask

task automatic test_rx_forwarding();
    int                      i;
    int                      rsp0;
    int                      dat0;
    logic [63:0]             r;
    chi_link_pkg::rsp_flit_t rf;
    chi_link_pkg::dat_flit_t df;
    chi_link_pkg::rsp_flit_t rsp_exp[$];
    chi_link_pkg::dat_flit_t dat_exp[$];
    begin_test("rx_forwarding");
    rsp_got.delete();
    dat_got.delete();
    rsp0 = rsp_grants;
    dat0 = dat_grants;
    if (rsp_grants - rsp_sent < 12 || dat_grants - dat_sent < 12) begin
        note_error("partner holds too few receive credits");
    end
    for (i = 0; i < 12; i++) begin
        r = rand_bits(24);
        rf = r[23:0];
        r = rand_bits(48);
        df = r[47:0];
        // every fourth flit hands a credit back
        if (i % 4 == 3) begin
            rf[chi_link_pkg::OPCODE_LSB +: chi_link_pkg::OPCODE_W] = chi_link_pkg::LCRD_RETURN_OP;
            df[chi_link_pkg::OPCODE_LSB +: chi_link_pkg::OPCODE_W] = chi_link_pkg::LCRD_RETURN_OP;
        end
        if (opcode_of(64'(rf)) != chi_link_pkg::LCRD_RETURN_OP) rsp_exp.push_back(rf);
        if (opcode_of(64'(df)) != chi_link_pkg::LCRD_RETURN_OP) dat_exp.push_back(df);
        @(posedge clk_i);
        rxrspflitv_i <= 1'b1;
        rxrspflit_i <= rf;
        rxdatflitv_i <= 1'b1;
        rxdatflit_i <= df;
        rsp_sent++;
        dat_sent++;
    end
    @(posedge clk_i);
    rxrspflitv_i <= 1'b0;
    rxdatflitv_i <= 1'b0;
    repeat (20) @(negedge clk_i);

    if (rsp_got.size() != rsp_exp.size()) report_mismatch(64'(rsp_exp.size()), 64'(rsp_got.size()));
    if (dat_got.size() != dat_exp.size()) report_mismatch(64'(dat_exp.size()), 64'(dat_got.size()));
    for (i = 0; i < rsp_exp.size() && i < rsp_got.size(); i++) begin
        if (rsp_got[i] !== rsp_exp[i]) report_mismatch(64'(rsp_exp[i]), 64'(rsp_got[i]));
    end
    for (i = 0; i < dat_exp.size() && i < dat_got.size(); i++) begin
        if (dat_got[i] !== dat_exp[i]) report_mismatch(64'(dat_exp[i]), 64'(dat_got[i]));
    end
    // one extra grant per flit, credit returns included
    if (rsp_grants - rsp0 != 12) report_mismatch(64'd12, 64'(rsp_grants - rsp0));
    if (dat_grants - dat0 != 12) report_mismatch(64'd12, 64'(dat_grants - dat0));
    end_test();
endtask

// ************************************************************************
// transmit request channel
// ************************************************************************

// sources hold each flit until their ready was seen
task automatic run_sources(input int cycles, input int credits);
    int c;
    for (c = 0; c < cycles; c++) begin
        @(posedge clk_i);
        if (rd_acc) rd_idx++;
        if (wr_acc) wr_idx++;
        rd_req_valid_i <= (rd_idx < 4);
        rd_req_flit_i <= rd_flits[rd_idx % 4];
        wr_req_valid_i <= (wr_idx < 4);
        wr_req_flit_i <= wr_flits[wr_idx % 4];
        txreqlcrdv_i <= (c < credits);
    end
endtask

task automatic test_tx_arbitration();
    int                      i;
    logic [63:0]             r;
    chi_link_pkg::req_flit_t exp_q[$];
    begin_test("tx_arbitration");
    tx_got.delete();
    for (i = 0; i < 4; i++) begin
        r = rand_bits(32);
        rd_flits[i] = r[31:0];
        r = rand_bits(32);
        wr_flits[i] = r[31:0];
        // read wins first, then the two alternate
        exp_q.push_back(rd_flits[i]);
        exp_q.push_back(wr_flits[i]);
    end
    rd_idx = 0;
    wr_idx = 0;
    run_sources(20, 4);
    @(negedge clk_i);
    if (tx_got.size() != 4) report_mismatch(64'd4, 64'(tx_got.size()));
    run_sources(20, 4);
    @(negedge clk_i);
    if (tx_got.size() != 8) report_mismatch(64'd8, 64'(tx_got.size()));
    for (i = 0; i < 8 && i < tx_got.size(); i++) begin
        if (tx_got[i] !== exp_q[i]) report_mismatch(64'(exp_q[i]), 64'(tx_got[i]));
    end
    end_test();
endtask

task automatic test_tx_deactivation();
    int                      i;
    int                      n;
    chi_link_pkg::req_flit_t ret;
    begin_test("tx_deactivation");
    ret = '0;
    ret[chi_link_pkg::OPCODE_LSB +: chi_link_pkg::OPCODE_W] = chi_link_pkg::LCRD_RETURN_OP;
    ret[chi_link_pkg::SRCID_LSB +: chi_link_pkg::SRCID_W] = NODE_ID;
    tx_got.delete();
    for (i = 0; i < 5; i++) begin
        @(posedge clk_i);
        txreqlcrdv_i <= 1'b1;
    end
    @(posedge clk_i);
    txreqlcrdv_i <= 1'b0;
    repeat (3) @(negedge clk_i);
    if (tx_got.size() != 0) report_mismatch(64'd0, 64'(tx_got.size()));

    @(posedge clk_i);
    link_en_i <= 1'b0;
    n = 0;
    while (txlinkactivereq_o !== 1'b0 && n < 10) begin
        @(negedge clk_i);
        n++;
    end
    if (txlinkactivereq_o !== 1'b0) note_error("txlinkactivereq_o never fell");
    // sources push while the held credits drain
    @(posedge clk_i);
    rd_req_valid_i <= 1'b1;
    wr_req_valid_i <= 1'b1;
    ready_seen = 1'b0;
    repeat (15) @(negedge clk_i);
    if (ready_seen) note_error("a ready rose during credit return");
    if (tx_got.size() != 5) report_mismatch(64'd5, 64'(tx_got.size()));
    for (i = 0; i < tx_got.size(); i++) begin
        if (tx_got[i] !== ret) report_mismatch(64'(ret), 64'(tx_got[i]));
    end

    @(posedge clk_i);
    txlinkactiveack_i <= 1'b0;
    rd_req_valid_i <= 1'b0;
    wr_req_valid_i <= 1'b0;
    repeat (2) @(negedge clk_i);
    if (txlinkactivereq_o !== 1'b0) report_mismatch(64'd0, 64'(txlinkactivereq_o));
    end_test();
endtask

task automatic test_rx_deactivation();
    int                      k;
    int                      n;
    int                      rsp_held;
    int                      dat_held;
    int                      dat_lag;
    int                      rsp0;
    int                      dat0;
    logic [63:0]             r;
    chi_link_pkg::rsp_flit_t rf;
    chi_link_pkg::dat_flit_t df;
    begin_test("rx_deactivation");
    rsp_got.delete();
    dat_got.delete();
    rsp_held = rsp_grants - rsp_sent;
    dat_held = dat_grants - dat_sent;
    // data returns trail the responses so the ack has to wait on both
    dat_lag = 5;
    rsp0 = rsp_grants;
    dat0 = dat_grants;
    @(posedge clk_i);
    rxlinkactivereq_i <= 1'b0;
    for (k = 0; k < rsp_held || k < dat_lag + dat_held; k++) begin
        r = rand_bits(24);
        rf = r[23:0];
        rf[chi_link_pkg::OPCODE_LSB +: chi_link_pkg::OPCODE_W] = chi_link_pkg::LCRD_RETURN_OP;
        r = rand_bits(48);
        df = r[47:0];
        df[chi_link_pkg::OPCODE_LSB +: chi_link_pkg::OPCODE_W] = chi_link_pkg::LCRD_RETURN_OP;
        @(posedge clk_i);
        rxrspflitv_i <= (k < rsp_held);
        rxrspflit_i <= rf;
        rxdatflitv_i <= (k >= dat_lag && k < dat_lag + dat_held);
        rxdatflit_i <= df;
        @(negedge clk_i);
        if (rxlinkactiveack_o !== 1'b1) report_mismatch(64'd1, 64'(rxlinkactiveack_o));
    end
    rsp_sent += rsp_held;
    dat_sent += dat_held;
    @(posedge clk_i);
    rxrspflitv_i <= 1'b0;
    rxdatflitv_i <= 1'b0;
    n = 0;
    while (rxlinkactiveack_o !== 1'b0 && n < 10) begin
        @(negedge clk_i);
        n++;
    end
    if (rxlinkactiveack_o !== 1'b0) note_error("rxlinkactiveack_o never fell");
    if (rsp_got.size() != 0) report_mismatch(64'd0, 64'(rsp_got.size()));
    if (dat_got.size() != 0) report_mismatch(64'd0, 64'(dat_got.size()));
    if (rsp_grants != rsp0) report_mismatch(64'(rsp0), 64'(rsp_grants));
    if (dat_grants != dat0) report_mismatch(64'(dat0), 64'(dat_grants));
    end_test();
endtask

`endif

// ==== dv/chi_link_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module chi_link_tb;

    localparam int         LCRD_NUM     = int'(chi_link_pkg::LCRD_NUM_DEF);
    localparam logic [6:0] NODE_ID      = 7'h11;
    localparam int         CLK_PERIOD   = 8;
    localparam int         RESET_CYCLES = 10;
    // rough cycle count of each test, in run order
    localparam int         TEST_CYCLES  = 30 + 50 + 40 + 50 + 45 + 40;
    localparam int         WATCHDOG_NS  = 2 * (RESET_CYCLES + TEST_CYCLES) * CLK_PERIOD;

    logic                    clk_i = 1'b0;
    logic                    rst_i;
    logic                    link_en_i;
    logic                    txlinkactivereq_o;
    logic                    txlinkactiveack_i;
    logic                    rxlinkactivereq_i;
    logic                    rxlinkactiveack_o;
    logic                    rxrspflitv_i;
    chi_link_pkg::rsp_flit_t rxrspflit_i;
    logic                    rxrsplcrdv_o;
    logic                    rxdatflitv_i;
    chi_link_pkg::dat_flit_t rxdatflit_i;
    logic                    rxdatlcrdv_o;
    logic                    txreqflitv_o;
    chi_link_pkg::req_flit_t txreqflit_o;
    logic                    txreqlcrdv_i;
    logic                    rd_req_valid_i;
    chi_link_pkg::req_flit_t rd_req_flit_i;
    logic                    rd_req_ready_o;
    logic                    wr_req_valid_i;
    chi_link_pkg::req_flit_t wr_req_flit_i;
    logic                    wr_req_ready_o;
    logic                    rsp_valid_o;
    chi_link_pkg::rsp_flit_t rsp_flit_o;
    logic                    dat_valid_o;
    chi_link_pkg::dat_flit_t dat_flit_o;

    // partner view of the link
    int                      rsp_grants;
    int                      dat_grants;
    int                      rsp_sent;
    int                      dat_sent;
    chi_link_pkg::rsp_flit_t rsp_got[$];
    chi_link_pkg::dat_flit_t dat_got[$];
    chi_link_pkg::req_flit_t tx_got[$];
    logic                    rd_acc;
    logic                    wr_acc;
    logic                    ready_seen;

    // local request sources for the arbitration test
    chi_link_pkg::req_flit_t rd_flits[4];
    chi_link_pkg::req_flit_t wr_flits[4];
    int                      rd_idx;
    int                      wr_idx;

    logic [31:0]             lfsr_q = 32'h011461fb;
    int                      errors;
    int                      tests_run;
    int                      test_err0;
    string                   cur_test;

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    chi_link_ctl chi_link_ctl_i (.*);

    // outputs are settled by the falling edge
    always @(negedge clk_i) begin
        if (rxrsplcrdv_o) rsp_grants++;
        if (rxdatlcrdv_o) dat_grants++;
        if (rsp_valid_o) rsp_got.push_back(rsp_flit_o);
        if (dat_valid_o) dat_got.push_back(dat_flit_o);
        if (txreqflitv_o) tx_got.push_back(txreqflit_o);
        if (rd_req_ready_o || wr_req_ready_o) ready_seen = 1'b1;
        rd_acc = rd_req_ready_o;
        wr_acc = wr_req_ready_o;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[62:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic logic [chi_link_pkg::OPCODE_W-1:0] opcode_of(input logic [63:0] f);
        return f[chi_link_pkg::OPCODE_LSB +: chi_link_pkg::OPCODE_W];
    endfunction

    task automatic begin_test(input string name);
        cur_test = name;
        test_err0 = errors;
        tests_run++;
    endtask

    task automatic end_test();
        if (errors == test_err0) begin
            $display("%s: done, no errors", cur_test);
        end else begin
            $display("%s: done, %0d errors", cur_test, errors - test_err0);
        end
    endtask

    task automatic report_mismatch(input logic [63:0] exp, input logic [63:0] act);
        $display("Fail %s expected %0h actual %0h", cur_test, exp, act);
        errors++;
    endtask

    task automatic note_error(input string msg);
        $display("%s: %s", cur_test, msg);
        errors++;
    endtask

    `include "chi_link_tests.svh"

    initial begin
        rst_i = 1'b1;
        link_en_i = 1'b0;
        txlinkactiveack_i = 1'b0;
        rxlinkactivereq_i = 1'b0;
        rxrspflitv_i = 1'b0;
        rxrspflit_i = '0;
        rxdatflitv_i = 1'b0;
        rxdatflit_i = '0;
        txreqlcrdv_i = 1'b0;
        rd_req_valid_i = 1'b0;
        rd_req_flit_i = '0;
        wr_req_valid_i = 1'b0;
        wr_req_flit_i = '0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_i <= 1'b0;

        test_reset_activate();
        test_rx_credit_grant();
        test_rx_forwarding();
        test_tx_arbitration();
        test_tx_deactivation();
        test_rx_deactivation();

        $display("tests %0d, errors %0d", tests_run, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns in %s", WATCHDOG_NS, cur_test);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== chi_link.f ====
+incdir+dv
src/chi_link_pkg.sv
src/lcrd_counter.sv
src/link_fsm.sv
src/rx_chan.sv
src/tx_req_chan.sv
src/chi_link_ctl.sv
dv/chi_link_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the chi_link testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f chi_link.f --top-module chi_link_tb

./obj_dir/Vchi_link_tb > sim.log
cat sim.log

grep -qx "Everything OK" sim.log
